//--- design/dma_pkg.sv
// shared widths and types; lengths are in bytes, 1 to 65535, and nibble counts need one extra bit
`default_nettype none

package dma_pkg;

    // bus widths
    localparam int ADDR_W = 32;     // descriptor and memory address
    localparam int LEN_W  = 16;     // byte length
    localparam int CNT_W  = LEN_W + 1;  // unit counters, nibble count reaches 2x length
    localparam int BYTE_W = 8;      // cpu side word
    localparam int NIB_W  = 4;      // memory side word

    // bank geometry
    localparam int BANK_DEPTH = 8;  // entries per bank
    localparam int PTR_W      = 3;  // log2 of BANK_DEPTH

    // transfer direction, latched per descriptor
    localparam logic DIR_CPU_TO_MEM = 1'b1;  // cpu is source
    localparam logic DIR_MEM_TO_CPU = 1'b0;  // memory is source

    // low/high nibble pair, memory view of one entry
    typedef struct packed {
        logic [NIB_W-1:0] hi;  // second nibble on the wire
        logic [NIB_W-1:0] lo;  // first nibble on the wire
    } nib_pair_t;

    // one bank entry: a whole byte for the cpu, a nibble pair for memory
    typedef union packed {
        logic [BYTE_W-1:0] whole;
        nib_pair_t         nib;
    } buf_word_t;

endpackage

`default_nettype wire

//--- design/byte_bank.sv
// fill only while not full and drain only while full; nibble fills must end on a high nibble
`default_nettype none
`timescale 1ns/100ps

module byte_bank
    import dma_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      fill_nibble,   // fill side takes nibbles on fill_data.nib.lo
    input  logic      fill_en,
    input  buf_word_t fill_data,
    input  logic      seal,          // close a partial bank
    input  logic      drain_nibble,  // drain side shows nibbles on drain_data.nib.lo
    input  logic      drain_en,
    output buf_word_t drain_data,
    output logic      full,
    output logic      empty
);

    buf_word_t        mem [BANK_DEPTH];
    logic [PTR_W-1:0] fill_ptr;
    logic [PTR_W-1:0] drain_ptr;
    logic             fill_phase;    // high nibble is next
    logic             drain_phase;   // high nibble is showing
    logic [PTR_W:0]   level;         // complete entries stored, 0..8
    logic             full_q;
    logic             fill_step;     // an entry completes this cycle
    logic             drain_step;    // an entry is used up this cycle
    logic             drain_done;    // last stored entry leaves
    buf_word_t        rd_word;

    assign fill_step  = fill_en & (~fill_nibble | fill_phase);
    assign drain_step = drain_en & full_q & (~drain_nibble | drain_phase);
    assign drain_done = drain_step
                        & ({1'b0, drain_ptr} + {{PTR_W{1'b0}}, 1'b1} == level);

    assign full  = full_q;
    assign empty = ~full_q & (level == '0) & ~fill_phase;

    // storage, no reset
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            if (!fill_nibble)
                mem[fill_ptr] <= fill_data;
            else if (!fill_phase)
                mem[fill_ptr].nib.lo <= fill_data.nib.lo;  // low nibble first
            else
                mem[fill_ptr].nib.hi <= fill_data.nib.lo;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            fill_ptr    <= '0;
            drain_ptr   <= '0;
            fill_phase  <= 1'b0;
            drain_phase <= 1'b0;
            level       <= '0;
            full_q      <= 1'b0;
        end
        else
        begin
            if (fill_en && fill_nibble)
                fill_phase <= ~fill_phase;
            if (fill_step)
            begin
                fill_ptr <= fill_ptr + 1'b1;  // wraps to 0 at depth
                level    <= level + 1'b1;
            end
            if ((fill_step && level == BANK_DEPTH - 1) || seal)
                full_q <= 1'b1;               // eighth entry or partial seal

            if (drain_en && full_q && drain_nibble)
                drain_phase <= ~drain_phase;
            if (drain_step)
                drain_ptr <= drain_ptr + 1'b1;
            if (drain_done)
            begin
                full_q    <= 1'b0;            // back to empty, rewind
                fill_ptr  <= '0;
                drain_ptr <= '0;
                level     <= '0;
            end
        end
    end

    // read side, nibble mode puts the current half in the low slot
    always_comb
    begin
        rd_word = mem[drain_ptr];
        if (drain_nibble)
        begin
            drain_data.nib.hi = '0;
            drain_data.nib.lo = drain_phase ? rd_word.nib.hi : rd_word.nib.lo;
        end
        else
            drain_data = rd_word;
    end

endmodule

`default_nettype wire

//--- design/bank_swap.sv
// only the two channels of the latched direction are used; the others stay idle with zero ready/valid
`default_nettype none
`timescale 1ns/100ps

module bank_swap
    import dma_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              dir,
    input  logic              src_open,
    input  logic              snk_open,
    input  logic              src_last,
    input  logic              cpu_wr_valid,
    input  logic [BYTE_W-1:0] cpu_wr_data,
    output logic              cpu_wr_ready,
    output logic              cpu_rd_valid,
    output logic [BYTE_W-1:0] cpu_rd_data,
    input  logic              cpu_rd_ready,
    output logic              mem_wr_valid,
    output logic [NIB_W-1:0]  mem_wr_data,
    input  logic              mem_wr_ready,
    input  logic              mem_rd_valid,
    input  logic [NIB_W-1:0]  mem_rd_data,
    output logic              mem_rd_ready,
    output logic              src_fire,
    output logic              snk_fire
);

    logic       fill_sel;     // 0 = bank_a takes source data
    logic       drain_sel;    // 0 = bank_a feeds the sink
    logic [1:0] bank_full;
    logic [1:0] bank_empty;
    logic [1:0] full_q;       // last cycle, for edge detect
    logic [1:0] empty_q;
    logic [1:0] fill_en;
    logic [1:0] drain_en;
    logic [1:0] seal;
    logic       cpu_src;
    logic       src_valid;
    logic       src_ready;
    logic       snk_valid;
    logic       snk_ready;
    buf_word_t  fill_word;
    buf_word_t  drain_word_a;
    buf_word_t  drain_word_b;
    buf_word_t  drain_word;

    assign cpu_src = (dir == DIR_CPU_TO_MEM);

    // source side, blocked while the fill bank is still full
    assign src_valid    = cpu_src ? cpu_wr_valid : mem_rd_valid;
    assign src_ready    = src_open & ~bank_full[fill_sel];
    assign src_fire     = src_valid & src_ready;
    assign cpu_wr_ready = cpu_src & src_ready;
    assign mem_rd_ready = ~cpu_src & src_ready;

    // sink side, data only from a sealed bank
    assign snk_valid    = snk_open & bank_full[drain_sel];
    assign snk_ready    = cpu_src ? mem_wr_ready : cpu_rd_ready;
    assign snk_fire     = snk_valid & snk_ready;
    assign mem_wr_valid = cpu_src & snk_valid;
    assign cpu_rd_valid = ~cpu_src & snk_valid;

    assign fill_en  = {src_fire & fill_sel, src_fire & ~fill_sel};
    assign seal     = {src_fire & src_last & fill_sel, src_fire & src_last & ~fill_sel};
    assign drain_en = {snk_fire & drain_sel, snk_fire & ~drain_sel};

    always_comb
    begin
        fill_word = '0;
        if (cpu_src)
            fill_word.whole = cpu_wr_data;
        else
            fill_word.nib.lo = mem_rd_data;   // nibble rides in the low slot
    end

    assign drain_word  = drain_sel ? drain_word_b : drain_word_a;
    assign cpu_rd_data = drain_word.whole;
    assign mem_wr_data = drain_word.nib.lo;

    // ping-pong: fill moves on when its bank fills, drain when its bank empties
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            fill_sel  <= 1'b0;
            drain_sel <= 1'b0;
            full_q    <= '0;
            empty_q   <= '1;   // banks start empty, no false edge
        end
        else
        begin
            full_q  <= bank_full;
            empty_q <= bank_empty;
            if (bank_full[fill_sel] && !full_q[fill_sel])
                fill_sel <= ~fill_sel;
            if (bank_empty[drain_sel] && !empty_q[drain_sel])
                drain_sel <= ~drain_sel;
        end
    end

    byte_bank bank_a (
        .clk          (clk),
        .resetn       (resetn),
        .fill_nibble  (~cpu_src),
        .fill_en      (fill_en[0]),
        .fill_data    (fill_word),
        .seal         (seal[0]),
        .drain_nibble (cpu_src),
        .drain_en     (drain_en[0]),
        .drain_data   (drain_word_a),
        .full         (bank_full[0]),
        .empty        (bank_empty[0])
    );

    byte_bank bank_b (
        .clk          (clk),
        .resetn       (resetn),
        .fill_nibble  (~cpu_src),
        .fill_en      (fill_en[1]),
        .fill_data    (fill_word),
        .seal         (seal[1]),
        .drain_nibble (cpu_src),
        .drain_en     (drain_en[1]),
        .drain_data   (drain_word_b),
        .full         (bank_full[1]),
        .empty        (bank_empty[1])
    );

endmodule

`default_nettype wire

//--- design/descriptor_ctrl.sv
// one descriptor in flight; desc_len must be 1 or more; memory source should wait for the address
`default_nettype none
`timescale 1ns/100ps

module descriptor_ctrl
    import dma_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              desc_valid,
    input  logic              desc_dir,
    input  logic [ADDR_W-1:0] desc_addr,
    input  logic [LEN_W-1:0]  desc_len,
    output logic              desc_ready,
    output logic              addr_out_valid,
    output logic [ADDR_W-1:0] addr_out,
    output logic              addr_out_write,
    input  logic              addr_out_ready,
    input  logic              src_fire,
    input  logic              snk_fire,
    output logic              dir,
    output logic              src_open,
    output logic              snk_open,
    output logic              src_last
);

    logic [ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]  len_q;
    logic [CNT_W-1:0]  src_cnt;      // units taken from the source
    logic [CNT_W-1:0]  snk_cnt;      // units given to the sink
    logic [CNT_W-1:0]  src_target;
    logic [CNT_W-1:0]  snk_target;
    logic              desc_fire;
    logic              addr_fire;
    logic              snk_last;     // final sink unit this cycle

    assign desc_fire = desc_valid & desc_ready;
    assign addr_fire = addr_out_valid & addr_out_ready;

    // bytes on the cpu side, nibbles (2x) on the memory side
    assign src_target = (dir == DIR_CPU_TO_MEM) ? {1'b0, len_q} : {len_q, 1'b0};
    assign snk_target = (dir == DIR_CPU_TO_MEM) ? {len_q, 1'b0} : {1'b0, len_q};

    assign src_last = src_open & (src_cnt == src_target - 1'b1);
    assign snk_last = snk_fire & (snk_cnt == snk_target - 1'b1);

    assign addr_out       = addr_q;
    assign addr_out_write = (dir == DIR_CPU_TO_MEM);  // memory gets written

    // descriptor payload
    always_ff @(posedge clk)
    begin
        if (desc_fire)
        begin
            addr_q <= desc_addr;
            len_q  <= desc_len;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            desc_ready     <= 1'b1;
            addr_out_valid <= 1'b0;
            dir            <= DIR_MEM_TO_CPU;
            src_open       <= 1'b0;
            snk_open       <= 1'b0;
            src_cnt        <= '0;
            snk_cnt        <= '0;
        end
        else
        begin
            if (desc_fire)
            begin
                desc_ready     <= 1'b0;
                addr_out_valid <= 1'b1;     // address goes out next cycle
                dir            <= desc_dir;
                src_open       <= 1'b1;
                snk_open       <= (desc_dir == DIR_MEM_TO_CPU);  // cpu sink opens at once
            end

            if (addr_fire)
            begin
                addr_out_valid <= 1'b0;
                if (dir == DIR_CPU_TO_MEM)
                    snk_open <= 1'b1;       // memory sink needs its address first
            end

            if (src_fire)
            begin
                src_cnt <= src_cnt + 1'b1;
                if (src_last)
                    src_open <= 1'b0;       // source done
            end

            if (snk_fire)
                snk_cnt <= snk_cnt + 1'b1;
            if (snk_last)
                snk_open <= 1'b0;

            // both sides at target, reopen for the next descriptor
            if (snk_last && src_cnt == src_target)
            begin
                desc_ready <= 1'b1;
                src_cnt    <= '0;
                snk_cnt    <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dma_top.sv
// cpu port is 8 bits and memory port is 4 bits, low nibble first; all channels are valid/ready
`default_nettype none
`timescale 1ns/100ps

module dma_top
    import dma_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    // descriptor from the cpu
    input  logic              desc_valid,
    input  logic              desc_dir,
    input  logic [ADDR_W-1:0] desc_addr,
    input  logic [LEN_W-1:0]  desc_len,
    output logic              desc_ready,
    // address to memory
    output logic              addr_out_valid,
    output logic [ADDR_W-1:0] addr_out,
    output logic              addr_out_write,
    input  logic              addr_out_ready,
    // cpu data
    input  logic              cpu_wr_valid,
    input  logic [BYTE_W-1:0] cpu_wr_data,
    output logic              cpu_wr_ready,
    output logic              cpu_rd_valid,
    output logic [BYTE_W-1:0] cpu_rd_data,
    input  logic              cpu_rd_ready,
    // memory data
    output logic              mem_wr_valid,
    output logic [NIB_W-1:0]  mem_wr_data,
    input  logic              mem_wr_ready,
    input  logic              mem_rd_valid,
    input  logic [NIB_W-1:0]  mem_rd_data,
    output logic              mem_rd_ready
);

    logic dir;        // latched direction
    logic src_open;
    logic snk_open;
    logic src_last;   // one source unit left
    logic src_fire;
    logic snk_fire;

    descriptor_ctrl u_ctrl (
        .clk            (clk),
        .resetn         (resetn),
        .desc_valid     (desc_valid),
        .desc_dir       (desc_dir),
        .desc_addr      (desc_addr),
        .desc_len       (desc_len),
        .desc_ready     (desc_ready),
        .addr_out_valid (addr_out_valid),
        .addr_out       (addr_out),
        .addr_out_write (addr_out_write),
        .addr_out_ready (addr_out_ready),
        .src_fire       (src_fire),
        .snk_fire       (snk_fire),
        .dir            (dir),
        .src_open       (src_open),
        .snk_open       (snk_open),
        .src_last       (src_last)
    );

    bank_swap u_swap (
        .clk          (clk),
        .resetn       (resetn),
        .dir          (dir),
        .src_open     (src_open),
        .snk_open     (snk_open),
        .src_last     (src_last),
        .cpu_wr_valid (cpu_wr_valid),
        .cpu_wr_data  (cpu_wr_data),
        .cpu_wr_ready (cpu_wr_ready),
        .cpu_rd_valid (cpu_rd_valid),
        .cpu_rd_data  (cpu_rd_data),
        .cpu_rd_ready (cpu_rd_ready),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_ready (mem_wr_ready),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_ready (mem_rd_ready),
        .src_fire     (src_fire),
        .snk_fire     (snk_fire)
    );

endmodule

`default_nettype wire

//--- testbench/tb_dma.sv
// one descriptor in flight at a time; inputs change on rising edges, main checks sample on falling edges
`default_nettype none
`timescale 1ns/100ps

module tb_dma
    import dma_pkg::*;
();

    localparam int CLK_NS      = 4;
    localparam int TOTAL_BYTES = 13 + 8 + 24 + 21 + 19;   // sum of all descriptor lengths
    localparam int WATCHDOG_NS = (TOTAL_BYTES * 200 + 16) * CLK_NS;

    logic              clk = 1'b0;
    logic              resetn;
    logic              desc_valid, desc_dir, desc_ready;
    logic [ADDR_W-1:0] desc_addr, addr_out;
    logic [LEN_W-1:0]  desc_len;
    logic              addr_out_valid, addr_out_write;
    logic              addr_out_ready = 1'b0;
    logic              cpu_wr_valid = 1'b0;
    logic [BYTE_W-1:0] cpu_wr_data = '0;
    logic              cpu_wr_ready, cpu_rd_valid;
    logic [BYTE_W-1:0] cpu_rd_data;
    logic              cpu_rd_ready = 1'b0;
    logic              mem_wr_valid, mem_rd_ready;
    logic [NIB_W-1:0]  mem_wr_data;
    logic              mem_wr_ready = 1'b0;
    logic              mem_rd_valid = 1'b0;
    logic [NIB_W-1:0]  mem_rd_data = '0;

    string             test_name = "reset";
    int                mismatches = 0;
    int                failures = 0;          // protocol and count errors
    bit                stalls = 1'b0;         // random back-pressure from the models
    bit                hold_mem_wr = 1'b0;    // memory refuses writes
    bit                mem_src_go = 1'b0;     // memory has seen a read address
    logic [ADDR_W-1:0] exp_addr = '0;
    logic              exp_write = 1'b0;
    int                addr_total = 0;        // address handshakes so far
    int                cpu_taken_total = 0;   // cpu bytes accepted so far
    logic [BYTE_W-1:0] cpu_src_q[$];
    logic [NIB_W-1:0]  mem_src_q[$];
    logic [NIB_W-1:0]  exp_nib_q[$];          // what memory should receive
    logic [BYTE_W-1:0] exp_byte_q[$];         // what the cpu should receive

    always #(CLK_NS / 2) clk = ~clk;

    dma_top uut (.*);

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual)
        else
        begin
            mismatches++;
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(string what);
        failures++;
        $display("ERROR in %s: %s", test_name, what);
    endtask

    // memory address port, read data may only start after the address
    always @(posedge clk)
    begin
        if (addr_out_valid && addr_out_ready)
        begin
            addr_total++;
            check_value("addr_out", int'(exp_addr), int'(addr_out));
            check_value("addr_out_write", int'(exp_write), int'(addr_out_write));
            mem_src_go <= !addr_out_write;
        end
        else if (desc_valid && desc_ready)
            mem_src_go <= 1'b0;               // new descriptor, wait for its address
        addr_out_ready <= resetn && (!stalls || $urandom % 3 != 0);
    end

    // cpu write source, holds valid and data until taken
    always @(posedge clk)
    begin
        if (cpu_wr_valid && cpu_wr_ready)
        begin
            void'(cpu_src_q.pop_front());
            cpu_taken_total++;
        end
        if (!cpu_wr_valid || cpu_wr_ready)
        begin
            if (cpu_src_q.size() > 0 && (!stalls || $urandom % 4 != 0))
            begin
                cpu_wr_valid <= 1'b1;
                cpu_wr_data  <= cpu_src_q[0];
            end
            else
                cpu_wr_valid <= 1'b0;
        end
    end

    // memory read source, low nibble of each byte first
    always @(posedge clk)
    begin
        if (mem_rd_valid && mem_rd_ready)
            void'(mem_src_q.pop_front());
        if (!mem_rd_valid || mem_rd_ready)
        begin
            if (mem_src_go && mem_src_q.size() > 0 && (!stalls || $urandom % 4 != 0))
            begin
                mem_rd_valid <= 1'b1;
                mem_rd_data  <= mem_src_q[0];
            end
            else
                mem_rd_valid <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        if (mem_wr_valid && mem_wr_ready)
        begin
            if (exp_nib_q.size() == 0)
                report_failure("memory got a nibble beyond the descriptor length");
            else
                check_value("mem_wr_data", int'(exp_nib_q.pop_front()), int'(mem_wr_data));
        end
        mem_wr_ready <= resetn && !hold_mem_wr && (!stalls || $urandom % 3 != 0);
    end

    always @(posedge clk)
    begin
        if (cpu_rd_valid && cpu_rd_ready)
        begin
            if (exp_byte_q.size() == 0)
                report_failure("cpu got a byte beyond the descriptor length");
            else
                check_value("cpu_rd_data", int'(exp_byte_q.pop_front()), int'(cpu_rd_data));
        end
        cpu_rd_ready <= resetn && (!stalls || $urandom % 3 != 0);
    end

    // a stalled sender keeps valid and data
    a_mem_wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        ($past(mem_wr_valid) && !$past(mem_wr_ready)) |-> (mem_wr_valid && $stable(mem_wr_data)))
        else report_failure("mem_wr valid or data changed while stalled");
    a_cpu_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        ($past(cpu_rd_valid) && !$past(cpu_rd_ready)) |-> (cpu_rd_valid && $stable(cpu_rd_data)))
        else report_failure("cpu_rd valid or data changed while stalled");
    a_addr_hold: assert property (@(posedge clk) disable iff (!resetn)
        ($past(addr_out_valid) && !$past(addr_out_ready)) |-> (addr_out_valid && $stable(addr_out)))
        else report_failure("address valid or value changed while stalled");
    // channels of the other direction stay quiet
    a_idle_rd: assert property (@(posedge clk) disable iff (!resetn)
        addr_out_write |-> (!cpu_rd_valid && !mem_rd_ready))
        else report_failure("read-direction channel active in a cpu to memory transfer");
    a_idle_wr: assert property (@(posedge clk) disable iff (!resetn)
        !addr_out_write |-> (!cpu_wr_ready && !mem_wr_valid))
        else report_failure("write-direction channel active in a memory to cpu transfer");

    task automatic check_idle();
        check_value("desc_ready", 1, int'(desc_ready));
        check_value("addr_out_valid", 0, int'(addr_out_valid));
        check_value("cpu_wr_ready", 0, int'(cpu_wr_ready));
        check_value("cpu_rd_valid", 0, int'(cpu_rd_valid));
        check_value("mem_wr_valid", 0, int'(mem_wr_valid));
        check_value("mem_rd_ready", 0, int'(mem_rd_ready));
    endtask

    // one descriptor from start to the end-of-transfer marker, entered on a falling edge
    task automatic run_desc(string name, logic dir, int len, bit with_stalls, bit block_mem);
        logic [BYTE_W-1:0] b;
        int                taken0;
        int                addr0;
        test_name   = name;
        stalls      = with_stalls;
        hold_mem_wr = block_mem;
        taken0      = cpu_taken_total;
        addr0       = addr_total;
        exp_addr    = $urandom;
        exp_write   = dir;
        for (int i = 0; i < len; i++)
        begin
            b = 8'($urandom);
            if (dir == DIR_CPU_TO_MEM)
            begin
                cpu_src_q.push_back(b);
                exp_nib_q.push_back(b[3:0]);      // low nibble leaves first
                exp_nib_q.push_back(b[7:4]);
            end
            else
            begin
                mem_src_q.push_back(b[3:0]);
                mem_src_q.push_back(b[7:4]);
                exp_byte_q.push_back(b);
            end
        end
        @(posedge clk);
        desc_valid <= 1'b1;
        desc_dir   <= dir;
        desc_addr  <= exp_addr;
        desc_len   <= LEN_W'(len);
        @(negedge clk);
        while (!desc_ready)
            @(negedge clk);
        @(posedge clk);                           // handshake on this edge
        desc_valid <= 1'b0;
        @(negedge clk);
        if (block_mem)
        begin
            repeat (48) @(negedge clk);           // long enough to fill both banks
            check_value("bytes taken while memory stalled", 16, cpu_taken_total - taken0);
            hold_mem_wr = 1'b0;
        end
        while (exp_nib_q.size() + exp_byte_q.size() > 0)
        begin
            assert (!desc_ready)
            else
                report_failure("desc_ready rose before the final sink handshake");
            @(negedge clk);
        end
        check_value("desc_ready after final sink handshake", 1, int'(desc_ready));
        check_value("address handshakes", 1, addr_total - addr0);
        if (dir == DIR_CPU_TO_MEM)
            check_value("cpu bytes taken", len, cpu_taken_total - taken0);
        else
            check_value("memory nibbles left", 0, mem_src_q.size());
    endtask

    initial
    begin
        void'($urandom(32'ha2ff));
        resetn     = 1'b0;
        desc_valid = 1'b0;
        desc_dir   = 1'b0;
        desc_addr  = '0;
        desc_len   = '0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_idle();
        run_desc("cpu_to_mem_13", DIR_CPU_TO_MEM, 13, 1'b0, 1'b0);    // partial last bank
        run_desc("mem_to_cpu_8", DIR_MEM_TO_CPU, 8, 1'b0, 1'b0);
        run_desc("mem_wr_blocked_24", DIR_CPU_TO_MEM, 24, 1'b0, 1'b1);
        run_desc("stall_cpu_to_mem_21", DIR_CPU_TO_MEM, 21, 1'b1, 1'b0);
        run_desc("stall_mem_to_cpu_19", DIR_MEM_TO_CPU, 19, 1'b1, 1'b0);
        test_name = "drain";
        repeat (8) @(negedge clk);                // any stray sink data shows up here
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog, 200 cycles per descriptor byte
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: transfers did not finish within %0d ns, stuck in %s",
                 WATCHDOG_NS, test_name);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/dma_pkg.sv
design/byte_bank.sv
design/bank_swap.sv
design/descriptor_ctrl.sv
design/dma_top.sv
testbench/tb_dma.sv

//--- Makefile
TOP := tb_dma

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir
